// ==== hdl/ifetch_pkg.sv ====
package ifetch_pkg;

  localparam int ITAG_LEN  = 22;
  localparam int IIDX_LEN  = 10; // 64 lines of 16 bytes
  localparam int ILINE_CNT = 64;
  localparam int IPAIR_CNT = 128;
  localparam int IQ_DEPTH  = 4;

  localparam logic [2:0]  UNCACHED_SEG = 3'b101;
  localparam logic [31:0] RESET_VPC    = 32'h8000_0000; // cached segment

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  burst_size; // beats minus one
    logic        cached;
    logic [1:0]  data_size;
    logic [31:0] addr;
    logic        data_ok;    // master takes read data
    logic        data_last;
    logic [3:0]  data_strobe;
    logic [31:0] w_data;
  } cache_bus_req_t;

  typedef struct packed {
    logic        ready;      // address accepted
    logic        data_ok;    // read beat valid
    logic        data_last;
    logic [31:0] r_data;
  } cache_bus_resp_t;

  typedef logic [1:0][31:0] inst_pair_t;

  typedef struct packed {
    logic [1:0]  valid;    // one per slot
    logic [31:0] vpc;      // pair aligned
    logic [31:0] attached;
    inst_pair_t  inst;
  } fetch_pair_t;

  typedef struct packed {
    logic                valid;
    logic [ITAG_LEN-1:0] tag;
  } itag_t;

endpackage

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/100ps

module fetch_pc_gen import ifetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clr_i,
  input  logic [31:0] redirect_pc_i,
  input  logic        ready_i,
  output logic [31:0] vpc_o,
  output logic [1:0]  valid_o,
  output logic [31:0] attached_o
);

  logic [31:0] pc_q;
  logic [31:0] seq_q; // running fetch number

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q  <= RESET_VPC;
      seq_q <= '0;
    end else if (clr_i) begin
      pc_q <= redirect_pc_i;
    end else if (ready_i) begin
      pc_q  <= vpc_o + 32'd8; // next pair with the odd-word offset dropped
      seq_q <= seq_q + 32'd1;
    end
  end

  assign vpc_o = {pc_q[31:3], 3'b000};

  // slot 0 off when entering on the second word
  assign valid_o    = {1'b1, ~pc_q[2]};
  assign attached_o = seq_q;

endmodule

// ==== hdl/addr_xlate.sv ====
`timescale 1ns/100ps

module addr_xlate import ifetch_pkg::*; (
  input  logic        clk,
  input  logic [31:0] vpc_i,
  input  logic [1:0]  valid_i,
  input  logic        ready_i,
  output logic [31:0] ppc_o,
  output logic        paddr_valid_o,
  output logic        uncached_o
);

  logic [31:0] ppc;
  logic        uncached;

  // fixed segment mapping clears the top three bits
  assign ppc      = {3'b000, vpc_i[28:0]};
  assign uncached = vpc_i[31:29] == UNCACHED_SEG;

  // one cycle behind vpc with the fetch register's enable
  always_ff @(posedge clk) begin
    if (ready_i) begin
      ppc_o         <= ppc;
      uncached_o    <= uncached;
      paddr_valid_o <= |valid_i;
    end
  end

endmodule

// ==== hdl/sram_1r1w.sv ====
`timescale 1ns/100ps

module sram_1r1w #(
  parameter type entry_t = logic,
  parameter int  depth   = 64
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(depth)-1:0] waddr_i,
  input  entry_t                   wdata_i,
  input  logic [$clog2(depth)-1:0] raddr_i,
  output entry_t                   rdata_o
);

  entry_t mem [depth];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem[raddr_i]; // async read

endmodule

// ==== hdl/icache_fetch.sv ====
`timescale 1ns/100ps

module icache_fetch import ifetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clr_i,
  input  logic [1:0]      valid_i,
  input  logic [31:0]     vpc_i,
  input  logic [31:0]     attached_i,
  output logic            ready_o,
  input  logic [31:0]     ppc_i,
  input  logic            paddr_valid_i,
  input  logic            uncached_i,
  input  logic            ready_i,
  output fetch_pair_t     out_o,
  output logic            push_o,
  output cache_bus_req_t  bus_req_o,
  input  cache_bus_resp_t bus_resp_i
);

  typedef enum logic [7:0] {
    st_normal  = 8'b0000_0001,
    st_rfaddr  = 8'b0000_0010,
    st_rfdata  = 8'b0000_0100,
    st_ucaddr0 = 8'b0000_1000,
    st_ucdata0 = 8'b0001_0000,
    st_ucaddr1 = 8'b0010_0000,
    st_ucdata1 = 8'b0100_0000,
    st_tclr    = 8'b1000_0000
  } fsm_t;

  function automatic logic [ITAG_LEN-1:0] tag_of(logic [31:0] a);
    return a[31:IIDX_LEN];
  endfunction

  function automatic logic [$clog2(ILINE_CNT)-1:0] line_idx(logic [31:0] a);
    return a[IIDX_LEN-1:4];
  endfunction

  function automatic logic [$clog2(IPAIR_CNT)-1:0] pair_idx(logic [31:0] a);
    return a[IIDX_LEN-1:3];
  endfunction

  fsm_t                         fsm_q, fsm_d;
  logic [31:0]                  f1_vpc_q;
  logic [1:0]                   f1_valid_q;
  logic [31:0]                  f1_att_q;
  logic [$clog2(ILINE_CNT)-1:0] tclr_cnt_q;
  logic [1:0]                   beat_cnt_q;  // word within the line
  logic [31:0]                  rf_shift_q;  // even beat waiting for its pair
  inst_pair_t                   remember_q;
  logic                         skid_q;
  logic                         uc_done_q, uc_done_d;
  logic                         beat, last_beat, hit;
  itag_t                        tag_rd, tag_wr;
  logic                         tag_we;
  logic [$clog2(ILINE_CNT)-1:0] tag_waddr;
  inst_pair_t                   pair_rd;
  logic                         pair_we;

  // fetch register
  always_ff @(posedge clk) begin
    if (!rst_n || clr_i) begin
      f1_valid_q <= '0;
    end else if (ready_o) begin
      f1_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_o) begin
      f1_vpc_q <= vpc_i;
      f1_att_q <= attached_i;
    end
  end

  sram_1r1w #(.entry_t(itag_t), .depth(ILINE_CNT)) i_tag_ram (
    .clk     (clk),
    .we_i    (tag_we),
    .waddr_i (tag_waddr),
    .wdata_i (tag_wr),
    .raddr_i (line_idx(f1_vpc_q)),
    .rdata_o (tag_rd)
  );

  sram_1r1w #(.entry_t(inst_pair_t), .depth(IPAIR_CNT)) i_data_ram (
    .clk     (clk),
    .we_i    (pair_we),
    .waddr_i ({line_idx(ppc_i), beat_cnt_q[1]}),
    .wdata_i ({bus_resp_i.r_data, rf_shift_q}),
    .raddr_i (pair_idx(f1_vpc_q)),
    .rdata_o (pair_rd)
  );

  assign beat      = bus_req_o.data_ok && bus_resp_i.data_ok;
  assign last_beat = beat && bus_resp_i.data_last;
  assign hit       = tag_rd.valid && tag_rd.tag == tag_of(ppc_i);
  assign pair_we   = fsm_q == st_rfdata && beat && beat_cnt_q[0]; // odd beat completes a pair

  always_comb begin
    tag_we    = 1'b0;
    tag_waddr = line_idx(ppc_i);
    tag_wr    = '{valid: 1'b1, tag: tag_of(ppc_i)};
    if (fsm_q == st_tclr) begin
      tag_we    = 1'b1;
      tag_waddr = tclr_cnt_q;
      tag_wr    = '0;
    end else if (fsm_q == st_rfdata && last_beat) begin
      tag_we = 1'b1; // line complete
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q      <= st_tclr;
      tclr_cnt_q <= '0;
      uc_done_q  <= 1'b0;
      skid_q     <= 1'b0;
    end else begin
      fsm_q     <= fsm_d;
      uc_done_q <= clr_i ? 1'b0 : uc_done_d;
      if (fsm_q == st_tclr) begin
        tclr_cnt_q <= tclr_cnt_q + 1'b1;
      end
      if (fsm_q != st_normal) begin
        skid_q <= 1'b1;
      end else if (ready_o) begin
        skid_q <= 1'b0; // held pair leaves
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_q == st_rfaddr) begin
      beat_cnt_q <= '0;
    end else if (beat) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
    if (beat) begin
      rf_shift_q <= bus_resp_i.r_data;
      case (fsm_q)
        st_rfdata: begin
          if (beat_cnt_q[1] == f1_vpc_q[3]) begin
            remember_q[beat_cnt_q[0]] <= bus_resp_i.r_data;
          end
        end
        st_ucdata0: remember_q[0] <= bus_resp_i.r_data;
        st_ucdata1: remember_q[1] <= bus_resp_i.r_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    fsm_d     = fsm_q;
    uc_done_d = ready_i ? 1'b0 : uc_done_q;
    case (fsm_q)
      st_tclr: begin
        if (tclr_cnt_q == ILINE_CNT - 1) begin
          fsm_d = st_normal;
        end
      end
      st_normal: begin
        if (paddr_valid_i && |f1_valid_q && !uc_done_q) begin
          if (uncached_i) begin
            fsm_d = f1_valid_q[0] ? st_ucaddr0 : st_ucaddr1;
          end else if (!hit) begin
            fsm_d = st_rfaddr;
          end
        end
      end
      st_rfaddr: begin
        if (bus_resp_i.ready) begin
          fsm_d = st_rfdata;
        end
      end
      st_rfdata: begin
        if (last_beat) begin
          fsm_d = st_normal;
        end
      end
      st_ucaddr0: begin
        if (bus_resp_i.ready) begin
          fsm_d = st_ucdata0;
        end
      end
      st_ucdata0: begin
        if (last_beat && f1_valid_q[1]) begin
          fsm_d = st_ucaddr1;
        end else if (last_beat) begin
          fsm_d     = st_normal;
          uc_done_d = 1'b1;
        end
      end
      st_ucaddr1: begin
        if (bus_resp_i.ready) begin
          fsm_d = st_ucdata1;
        end
      end
      st_ucdata1: begin
        if (last_beat) begin
          fsm_d     = st_normal;
          uc_done_d = 1'b1;
        end
      end
      default: fsm_d = st_normal;
    endcase
  end

  assign ready_o = ready_i && fsm_q == st_normal &&
                   ((hit && !uncached_i) || !(|f1_valid_q) || uc_done_q);

  always_comb begin
    out_o.valid    = ready_o ? f1_valid_q : 2'b00;
    out_o.vpc      = f1_vpc_q;
    out_o.attached = f1_att_q;
    out_o.inst     = skid_q ? remember_q : pair_rd;
  end

  assign push_o = |out_o.valid;

  always_comb begin
    bus_req_o            = '0;
    bus_req_o.burst_size = 4'd3;
    bus_req_o.data_size  = 2'b10; // word
    bus_req_o.addr       = {ppc_i[31:4], 4'b0000};
    case (fsm_q)
      st_rfaddr: begin
        bus_req_o.valid  = 1'b1;
        bus_req_o.cached = 1'b1;
      end
      st_ucaddr0, st_ucaddr1: begin
        bus_req_o.valid      = 1'b1;
        bus_req_o.burst_size = 4'd0;
        bus_req_o.addr       = {ppc_i[31:3], fsm_q == st_ucaddr1, 2'b00};
      end
      st_rfdata, st_ucdata0, st_ucdata1: bus_req_o.data_ok = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/100ps

module inst_queue import ifetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clr_i,
  input  logic        push_i,
  input  fetch_pair_t data_i,
  output logic        full_o,
  output fetch_pair_t q_o,
  output logic        q_valid_o,
  input  logic        q_ready_i
);

  fetch_pair_t mem [IQ_DEPTH];

  logic [$clog2(IQ_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(IQ_DEPTH):0]   count_q;
  logic                        do_push, do_pop;

  assign full_o    = count_q == IQ_DEPTH;
  assign q_valid_o = count_q != '0;
  assign q_o       = mem[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = q_valid_o && q_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n || clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + do_push - do_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hdl/ifetch_top.sv ====
`timescale 1ns/100ps

module ifetch_top import ifetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clr_i,
  input  logic [31:0]     redirect_pc_i,
  output cache_bus_req_t  bus_req_o,
  input  cache_bus_resp_t bus_resp_i,
  output fetch_pair_t     q_o,
  output logic            q_valid_o,
  input  logic            q_ready_i
);

  logic [31:0] gen_vpc, gen_attached, ppc;
  logic [1:0]  gen_valid;
  logic        fetch_ready, paddr_valid, uncached;
  logic        q_full, push;
  fetch_pair_t fetch_out;

  fetch_pc_gen i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .clr_i         (clr_i),
    .redirect_pc_i (redirect_pc_i),
    .ready_i       (fetch_ready),
    .vpc_o         (gen_vpc),
    .valid_o       (gen_valid),
    .attached_o    (gen_attached)
  );

  addr_xlate i_xlate (
    .clk           (clk),
    .vpc_i         (gen_vpc),
    .valid_i       (gen_valid),
    .ready_i       (fetch_ready),
    .ppc_o         (ppc),
    .paddr_valid_o (paddr_valid),
    .uncached_o    (uncached)
  );

  icache_fetch i_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .clr_i         (clr_i),
    .valid_i       (gen_valid),
    .vpc_i         (gen_vpc),
    .attached_i    (gen_attached),
    .ready_o       (fetch_ready),
    .ppc_i         (ppc),
    .paddr_valid_i (paddr_valid),
    .uncached_i    (uncached),
    .ready_i       (~q_full),
    .out_o         (fetch_out),
    .push_o        (push),
    .bus_req_o     (bus_req_o),
    .bus_resp_i    (bus_resp_i)
  );

  inst_queue i_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .clr_i     (clr_i),
    .push_i    (push),
    .data_i    (fetch_out),
    .full_o    (q_full),
    .q_o       (q_o),
    .q_valid_o (q_valid_o),
    .q_ready_i (q_ready_i)
  );

endmodule

// ==== sim/ifetch_properties.sv ====
`timescale 1ns/100ps

module ifetch_properties import ifetch_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input cache_bus_req_t  bus_req_i,
  input cache_bus_resp_t bus_resp_i,
  input logic            q_valid_i
);

  int unsigned fail_cnt = 0;

  // line refill is one aligned 4-beat burst
  a_refill_req: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i.valid && bus_req_i.cached |->
      bus_req_i.burst_size == 4'd3 && bus_req_i.addr[3:0] == 4'h0)
  else begin
    $error("refill request is not an aligned 4-beat burst");
    fail_cnt++;
  end

  a_uncached_req: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i.valid && !bus_req_i.cached |->
      bus_req_i.burst_size == 4'd0 && bus_req_i.addr[1:0] == 2'b00)
  else begin
    $error("uncached request is not a single word read");
    fail_cnt++;
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i.valid && !bus_resp_i.ready |=>
      bus_req_i.valid && $stable(bus_req_i.addr)) // held until accepted
  else begin
    $error("bus request dropped or changed before it was accepted");
    fail_cnt++;
  end

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !q_valid_i && !bus_req_i.valid)
  else begin
    $error("queue or bus request active right after reset");
    fail_cnt++;
  end

endmodule

// ==== sim/tb_ifetch_top.sv ====
`timescale 1ns/100ps

module tb_ifetch_top import ifetch_pkg::*; ();

  localparam int          RUN_CYCLES     = 3000;
  localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
  localparam int          STALL_LIMIT    = 200; // far above a refill or two uncached reads
  localparam logic [31:0] DATA_KEY       = 32'h5a5a_0f0f;

  logic            clk           = 1'b0;
  logic            rst_n         = 1'b0;
  logic            clr_i         = 1'b0;
  logic [31:0]     redirect_pc_i = '0;
  cache_bus_resp_t bus_resp_i    = '0;
  logic            q_ready_i     = 1'b0;
  cache_bus_req_t  bus_req_o;
  fetch_pair_t     q_o;
  logic            q_valid_o;

  logic [31:0] rnd         = 32'hdaeffbd2;
  int          cycle       = 0;
  int          errors      = 0;
  int          pops        = 0;
  int          idle_cycles = 0;
  logic [1:0]  m_state     = 2'd0; // idle, wait, data
  logic [1:0]  m_wait;
  logic [31:0] m_addr;
  logic [4:0]  m_left;
  logic        after_clr   = 1'b0;
  logic        have_prev   = 1'b0;
  logic [31:0] clr_target, prev_vpc, prev_att;

  always #20 clk = ~clk;

  ifetch_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .clr_i         (clr_i),
    .redirect_pc_i (redirect_pc_i),
    .bus_req_o     (bus_req_o),
    .bus_resp_i    (bus_resp_i),
    .q_o           (q_o),
    .q_valid_o     (q_valid_o),
    .q_ready_i     (q_ready_i)
  );

  bind ifetch_top ifetch_properties i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_req_i  (bus_req_o),
    .bus_resp_i (bus_resp_i),
    .q_valid_i  (q_valid_o)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory word is the physical byte address xor key
  function automatic logic [31:0] expected_word(input logic [31:0] vpc, input int slot);
    logic [31:0] paddr;
    paddr = {3'b000, vpc[28:0]} + 32'(4 * slot);
    return paddr ^ DATA_KEY;
  endfunction

  task respond_bus;
    cache_bus_resp_t resp;
    resp = '0;
    case (m_state)
      2'd0: begin
        if (bus_req_o.valid) begin
          rnd    = lcg_step(rnd);
          m_addr = bus_req_o.addr;
          m_left = bus_req_o.burst_size + 5'd1;
          m_wait = rnd[31:30];
          if (m_wait == 2'd0) begin
            resp.ready = 1'b1;
            m_state    = 2'd2;
          end else begin
            m_state = 2'd1;
          end
        end
      end
      2'd1: begin
        m_wait = m_wait - 2'd1;
        if (m_wait == 2'd0) begin
          resp.ready = 1'b1;
          m_state    = 2'd2;
        end
      end
      default: begin
        if (bus_resp_i.data_ok && bus_req_o.data_ok) begin // beat taken
          m_addr = m_addr + 32'd4;
          m_left = m_left - 5'd1;
        end
        if (m_left == 5'd0) begin
          m_state = 2'd0;
        end else begin
          resp.data_ok   = 1'b1;
          resp.data_last = m_left == 5'd1;
          resp.r_data    = m_addr ^ DATA_KEY;
        end
      end
    endcase
    bus_resp_i <= resp;
  endtask

  task pace_consumer;
    rnd = lcg_step(rnd);
    q_ready_i <= rnd[31:30] != 2'd0;
  endtask

  task pick_redirect;
    logic [2:0] seg;
    rnd = lcg_step(rnd);
    clr_i <= 1'b0;
    if (!clr_i && rnd[31:26] == 6'd0) begin
      seg = (rnd[25:24] == 2'd0) ? UNCACHED_SEG : 3'b100;
      clr_i         <= 1'b1;
      redirect_pc_i <= {seg, 17'd0, rnd[23:14], 2'b00}; // any word including odd ones
    end
  endtask

  task check_pair;
    logic [31:0] exp;
    logic [1:0]  exp_valid;
    int          i;
    for (i = 0; i < 2; i++) begin
      exp = expected_word(q_o.vpc, i);
      if (q_o.valid[i]) begin
        assert (q_o.inst[i] == exp) else begin
          $display("FAILED q_o.inst[%0d] vpc %h: expected %h, got %h", i, q_o.vpc, exp,
                   q_o.inst[i]);
          errors = errors + 1;
        end
      end
    end
    if (after_clr) begin
      exp_valid = clr_target[2] ? 2'b10 : 2'b11;
      assert (q_o.vpc == {clr_target[31:3], 3'b000}) else begin
        $display("FAILED q_o.vpc after redirect: expected %h, got %h",
                 {clr_target[31:3], 3'b000}, q_o.vpc);
        errors = errors + 1;
      end
      assert (q_o.valid == exp_valid) else begin
        $display("FAILED q_o.valid after redirect to %h: expected %h, got %h", clr_target,
                 exp_valid, q_o.valid);
        errors = errors + 1;
      end
    end else if (have_prev) begin
      assert (q_o.vpc == prev_vpc + 32'd8) else begin
        $display("FAILED q_o.vpc in sequence: expected %h, got %h", prev_vpc + 32'd8, q_o.vpc);
        errors = errors + 1;
      end
      assert (q_o.valid == 2'b11) else begin
        $display("FAILED q_o.valid in sequence: expected 3, got %h", q_o.valid);
        errors = errors + 1;
      end
      assert (q_o.attached == prev_att + 32'd1) else begin
        $display("FAILED q_o.attached in sequence: expected %h, got %h", prev_att + 32'd1,
                 q_o.attached);
        errors = errors + 1;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      m_state = 2'd0;
      bus_resp_i <= '0;
    end else begin
      respond_bus();
      pace_consumer();
      pick_redirect();
    end
  end

  // queue output checks
  always @(posedge clk) begin
    if (!rst_n) begin
      after_clr  <= 1'b1; // first pair starts at the reset pc
      have_prev  <= 1'b0;
      clr_target <= RESET_VPC;
    end else if (clr_i) begin
      after_clr  <= 1'b1;
      have_prev  <= 1'b0;
      clr_target <= redirect_pc_i;
    end else if (q_valid_o && q_ready_i) begin
      check_pair();
      pops      <= pops + 1;
      prev_vpc  <= q_o.vpc;
      prev_att  <= q_o.attached;
      have_prev <= 1'b1;
      after_clr <= 1'b0;
    end
    if (!rst_n || (q_valid_o && q_ready_i)) begin
      idle_cycles <= 0;
    end else if (idle_cycles == STALL_LIMIT) begin
      $display("no fetch pair left the queue for %0d cycles", STALL_LIMIT);
      errors = errors + 1;
      idle_cycles <= 0;
    end else begin
      idle_cycles <= idle_cycles + 1;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      $display("run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (cycle < RUN_CYCLES) begin
      @(posedge clk);
    end
    $display("errors: %0d queue checks, %0d bus properties, %0d pairs popped", errors,
             i_dut.i_props.fail_cnt, pops);
    if (errors == 0 && i_dut.i_props.fail_cnt == 0 && pops > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== ifetch_subsys.f ====
hdl/ifetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/addr_xlate.sv
hdl/sram_1r1w.sv
hdl/icache_fetch.sv
hdl/inst_queue.sv
hdl/ifetch_top.sv
sim/ifetch_properties.sv
sim/tb_ifetch_top.sv
